// File: wlast_pkg.sv
// Shared widths and field types for the AXI write-address and write-data path
`default_nettype none

package wlast_pkg;

    // Transaction id width on the AW channel
    localparam int ID_W = 4;

    // Byte address width
    localparam int ADDR_W = 32;

    // AXI len field, which holds the beat count of a burst minus one
    localparam int LEN_W = 8;

    // Write data width and one strobe bit per data byte
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Packed AW payload is {id, addr, len}
    localparam int AW_BITS = ID_W + ADDR_W + LEN_W;

    // Packed W payload is {data, strb}, with no last flag from the master
    localparam int W_BITS = DATA_W + STRB_W;

    // Field types, so a width mismatch between blocks shows up at the port
    typedef logic [ID_W-1:0] id_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

endpackage

`default_nettype wire

// File: wr_ingress_fifo.sv
// Two-entry valid/ready ingress FIFO that breaks timing between master and aligner
`timescale 1ns/1ps
`default_nettype none

module wr_ingress_fifo
#(
    parameter int WIDTH = 8
)
(
    input  wire              clk,
    input  wire              rst,

    // Write side, from the master
    input  wire              enq_valid,
    input  wire [WIDTH-1:0]  enq_data,
    output logic             enq_ready,

    // Read side, head of the queue
    output logic             deq_avail,
    output logic [WIDTH-1:0] deq_data,
    input  wire              deq_en
);

    // Two payload slots, written at wr_ptr and read at rd_ptr
    logic [WIDTH-1:0] mem [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             do_enq;
    logic             do_deq;

    // Both flags come straight from the registered count
    assign enq_ready = (count != 2'd2);
    assign deq_avail = (count != 2'd0);
    assign deq_data  = mem[rd_ptr];

    assign do_enq = enq_valid && enq_ready;
    // A pop only takes effect while the head holds data
    assign do_deq = deq_en && deq_avail;

    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (do_deq)
            begin
                rd_ptr <= ~rd_ptr;
            end
            // A push and a pop on the same edge leave the count unchanged
            case ({do_enq, do_deq})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: burst_sop_tracker.sv
// Beat counter that flags the first and last beat of each write burst
`timescale 1ns/1ps
`default_nettype none

module burst_sop_tracker
    import wlast_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       beat_fire,
    input  wire len_t burst_len,
    output logic      sop,
    output logic      eop
);

    len_t beat_cnt;
    len_t len_q;
    len_t cur_len;

    // A zero count means the next beat opens a burst
    assign sop = (beat_cnt == '0);

    // On the first beat the length comes live from the address head,
    // after that from the copy taken on that first beat
    assign cur_len = sop ? burst_len : len_q;
    assign eop     = (beat_cnt == cur_len);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt <= '0;
        end
        else if (beat_fire)
        begin
            // Wrap back to zero on the last beat so sop is set for the next burst
            if (eop)
            begin
                beat_cnt <= '0;
            end
            else
            begin
                beat_cnt <= beat_cnt + len_t'(1);
            end
        end
    end

    // The address leaves with the first beat, so its length must be kept here
    always_ff @(posedge clk)
    begin
        if (beat_fire && sop)
        begin
            len_q <= burst_len;
        end
    end

endmodule

`default_nettype wire

// File: wlast_fixup.sv
// Aligns each burst's first data beat with its address and rebuilds the last flag
`timescale 1ns/1ps
`default_nettype none

module wlast_fixup
    import wlast_pkg::*;
(
    input  wire                clk,
    input  wire                rst,

    // Head of the AW ingress FIFO
    input  wire                aw_avail,
    input  wire [AW_BITS-1:0]  aw_head,
    output logic               aw_deq,

    // Head of the W ingress FIFO
    input  wire                w_avail,
    input  wire [W_BITS-1:0]   w_head,
    output logic               w_deq,

    // Combined beat towards the skid slice
    output logic               fx_valid,
    output logic               fx_has_aw,
    output id_t                fx_id,
    output addr_t              fx_addr,
    output len_t               fx_len,
    output data_t              fx_data,
    output strb_t              fx_strb,
    output logic               fx_last,
    input  wire                fx_ready
);

    logic sop;
    logic eop;
    logic beat_fire;

    // Unpack the queue heads in the same order the top packs them
    assign {fx_id, fx_addr, fx_len} = aw_head;
    assign {fx_data, fx_strb}       = w_head;

    // A burst may only start once its address is also waiting.
    // Mid-burst beats need nothing but data, since the address has already gone
    assign fx_valid  = w_avail && (!sop || aw_avail);
    assign fx_has_aw = sop;

    // Valid does not look at ready, so the slice sees a clean handshake
    assign beat_fire = fx_valid && fx_ready;

    // The address is popped together with the first beat of its burst
    assign aw_deq = beat_fire && sop;
    assign w_deq  = beat_fire;

    // This flag is the whole reason for the stage
    assign fx_last = eop;

    // Tracker advances on every beat handed to the slice and keeps the
    // burst length after the address FIFO has moved on to the next request
    burst_sop_tracker u_tracker
    (
        .clk       (clk),
        .rst       (rst),
        .beat_fire (beat_fire),
        .burst_len (fx_len),
        .sop       (sop),
        .eop       (eop)
    );

endmodule

`default_nettype wire

// File: wr_skid_slice.sv
// Registered output slice with a skid entry for the combined address and data beat
`timescale 1ns/1ps
`default_nettype none

module wr_skid_slice
    import wlast_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // Combined beat from the fixup stage
    input  wire         fx_valid,
    input  wire         fx_has_aw,
    input  wire id_t    fx_id,
    input  wire addr_t  fx_addr,
    input  wire len_t   fx_len,
    input  wire data_t  fx_data,
    input  wire strb_t  fx_strb,
    input  wire         fx_last,
    output logic        fx_ready,

    // Memory side, all driven from the main register
    output logic        m_awvalid,
    output id_t         m_awid,
    output addr_t       m_awaddr,
    output len_t        m_awlen,
    input  wire         m_awready,
    output logic        m_wvalid,
    output data_t       m_wdata,
    output strb_t       m_wstrb,
    output logic        m_wlast,
    input  wire         m_wready
);

    // One beat is {has_aw, id, addr, len, data, strb, last}
    logic [AW_BITS+W_BITS+1:0] fx_beat;
    logic [AW_BITS+W_BITS+1:0] main_beat;
    logic [AW_BITS+W_BITS+1:0] skid_beat;
    logic                      main_valid;
    logic                      skid_valid;
    logic                      main_has_aw;
    logic                      accept;
    logic                      retire;
    logic                      main_free;

    assign fx_beat = {fx_has_aw, fx_id, fx_addr, fx_len, fx_data, fx_strb, fx_last};
    assign {main_has_aw, m_awid, m_awaddr, m_awlen, m_wdata, m_wstrb, m_wlast} = main_beat;

    // The address is only offered alongside the first data beat of its burst
    assign m_wvalid  = main_valid;
    assign m_awvalid = main_valid && main_has_aw;

    // A beat with an address needs both channels to take it on the same edge
    assign retire = main_valid && m_wready && (!main_has_aw || m_awready);

    // Ready is a pure flop output; an empty skid entry can always absorb one beat
    assign fx_ready  = !skid_valid;
    assign accept    = fx_valid && fx_ready;
    assign main_free = !main_valid || retire;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // The skid entry drains first to keep beats in order
            main_valid <= skid_valid || accept;
            skid_valid <= 1'b0;
        end
        else if (accept)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            main_beat <= skid_valid ? skid_beat : fx_beat;
        end
        // Parked beat while the memory side stalls
        if (accept && !main_free)
        begin
            skid_beat <= fx_beat;
        end
    end

endmodule

`default_nettype wire

// File: wr_path_top.sv
// Write path top with ingress FIFOs, WLAST fixup and registered memory-side slice
`timescale 1ns/1ps
`default_nettype none

module wr_path_top
    import wlast_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // Master side, W carries no last flag
    input  wire         s_awvalid,
    input  wire id_t    s_awid,
    input  wire addr_t  s_awaddr,
    input  wire len_t   s_awlen,
    output logic        s_awready,
    input  wire         s_wvalid,
    input  wire data_t  s_wdata,
    input  wire strb_t  s_wstrb,
    output logic        s_wready,

    // Memory side
    output logic        m_awvalid,
    output id_t         m_awid,
    output addr_t       m_awaddr,
    output len_t        m_awlen,
    input  wire         m_awready,
    output logic        m_wvalid,
    output data_t       m_wdata,
    output strb_t       m_wstrb,
    output logic        m_wlast,
    input  wire         m_wready
);

    logic               aw_avail;
    logic [AW_BITS-1:0] aw_head;
    logic               aw_deq;
    logic               w_avail;
    logic [W_BITS-1:0]  w_head;
    logic               w_deq;

    logic               fx_valid;
    logic               fx_has_aw;
    id_t                fx_id;
    addr_t              fx_addr;
    len_t               fx_len;
    data_t              fx_data;
    strb_t              fx_strb;
    logic               fx_last;
    logic               fx_ready;

    // Address requests, packed as {id, addr, len}
    wr_ingress_fifo #(.WIDTH(AW_BITS)) aw_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .enq_valid (s_awvalid),
        .enq_data  ({s_awid, s_awaddr, s_awlen}),
        .enq_ready (s_awready),
        .deq_avail (aw_avail),
        .deq_data  (aw_head),
        .deq_en    (aw_deq)
    );

    // Write beats, packed as {data, strb}
    wr_ingress_fifo #(.WIDTH(W_BITS)) w_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .enq_valid (s_wvalid),
        .enq_data  ({s_wdata, s_wstrb}),
        .enq_ready (s_wready),
        .deq_avail (w_avail),
        .deq_data  (w_head),
        .deq_en    (w_deq)
    );

    wlast_fixup u_fixup
    (
        .clk       (clk),
        .rst       (rst),
        .aw_avail  (aw_avail),
        .aw_head   (aw_head),
        .aw_deq    (aw_deq),
        .w_avail   (w_avail),
        .w_head    (w_head),
        .w_deq     (w_deq),
        .fx_valid  (fx_valid),
        .fx_has_aw (fx_has_aw),
        .fx_id     (fx_id),
        .fx_addr   (fx_addr),
        .fx_len    (fx_len),
        .fx_data   (fx_data),
        .fx_strb   (fx_strb),
        .fx_last   (fx_last),
        .fx_ready  (fx_ready)
    );

    // Memory port outputs all come from flops inside the slice
    wr_skid_slice u_slice
    (
        .clk       (clk),
        .rst       (rst),
        .fx_valid  (fx_valid),
        .fx_has_aw (fx_has_aw),
        .fx_id     (fx_id),
        .fx_addr   (fx_addr),
        .fx_len    (fx_len),
        .fx_data   (fx_data),
        .fx_strb   (fx_strb),
        .fx_last   (fx_last),
        .fx_ready  (fx_ready),
        .m_awvalid (m_awvalid),
        .m_awid    (m_awid),
        .m_awaddr  (m_awaddr),
        .m_awlen   (m_awlen),
        .m_awready (m_awready),
        .m_wvalid  (m_wvalid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_wready  (m_wready)
    );

endmodule

`default_nettype wire

// File: wr_path_chk.sv
// Handshake and reset assertions for the memory side of the write path
`timescale 1ns/1ps
`default_nettype none

module wr_path_chk
    import wlast_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         s_awready,
    input  wire         s_wready,
    input  wire         m_awvalid,
    input  wire id_t    m_awid,
    input  wire addr_t  m_awaddr,
    input  wire len_t   m_awlen,
    input  wire         m_awready,
    input  wire         m_wvalid,
    input  wire data_t  m_wdata,
    input  wire strb_t  m_wstrb,
    input  wire         m_wlast,
    input  wire         m_wready
);

    // One counter per assertion, summed for the testbench
    int   fail_reset = 0;
    int   fail_aw_w = 0;
    int   fail_w_hold = 0;
    int   fail_aw_hold = 0;
    int   fail_aw_first = 0;
    int   fail_count;
    logic retire;
    logic expect_aw;

    assign fail_count = fail_reset + fail_aw_w + fail_w_hold + fail_aw_hold + fail_aw_first;

    // A held beat leaves only when every channel it occupies is ready
    assign retire = m_wvalid && m_wready && (!m_awvalid || m_awready);

    // The next beat opens a burst after reset and after every last beat
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            expect_aw <= 1'b1;
        end
        else if (retire)
        begin
            expect_aw <= m_wlast;
        end
    end

    // Quiet memory side and open master side for as long as reset is held
    a_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!m_awvalid && !m_wvalid && s_awready && s_wready))
    else
    begin
        fail_reset = fail_reset + 1;
        $error("memory side active or master side blocked during reset");
    end

    // An address never travels without its first data beat
    a_aw_w: assert property (@(posedge clk) disable iff (rst) m_awvalid |-> m_wvalid)
    else
    begin
        fail_aw_w = fail_aw_w + 1;
        $error("m_awvalid high without m_wvalid");
    end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (m_wvalid && !retire) |=> (m_wvalid && $stable({m_wdata, m_wstrb, m_wlast})))
    else
    begin
        fail_w_hold = fail_w_hold + 1;
        $error("W beat dropped or changed before its transfer");
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (m_awvalid && !retire) |=> (m_awvalid && $stable({m_awid, m_awaddr, m_awlen})))
    else
    begin
        fail_aw_hold = fail_aw_hold + 1;
        $error("AW request dropped or changed before its transfer");
    end

    // Address shows only on the first beat of a burst
    a_aw_first: assert property (@(posedge clk) disable iff (rst)
        m_wvalid |-> (m_awvalid == expect_aw))
    else
    begin
        fail_aw_first = fail_aw_first + 1;
        $error("m_awvalid does not match the start of a burst");
    end

endmodule

bind wr_path_top wr_path_chk u_chk (.*);

`default_nettype wire

// File: tb_wr_path.sv
// Testbench for the write path with random bursts, memory back-pressure and an in-order model
`timescale 1ns/1ps
`default_nettype none

module tb_wr_path
    import wlast_pkg::*;
();

    localparam int          NUM_BURSTS     = 40;
    localparam int          MAX_BEATS      = 8;
    localparam int          TIMEOUT_CYCLES = NUM_BURSTS * MAX_BEATS * 4 + 200;
    localparam logic [31:0] SEED           = 32'h68e9d575;

    logic  clk;
    logic  rst;
    logic  s_awvalid;
    id_t   s_awid;
    addr_t s_awaddr;
    len_t  s_awlen;
    logic  s_awready;
    logic  s_wvalid;
    data_t s_wdata;
    strb_t s_wstrb;
    logic  s_wready;
    logic  m_awvalid;
    id_t   m_awid;
    addr_t m_awaddr;
    len_t  m_awlen;
    logic  m_awready;
    logic  m_wvalid;
    data_t m_wdata;
    strb_t m_wstrb;
    logic  m_wlast;
    logic  m_wready;

    // Bursts and beats chosen before the run starts
    id_t   burst_id   [NUM_BURSTS];
    addr_t burst_addr [NUM_BURSTS];
    len_t  burst_len  [NUM_BURSTS];
    data_t beat_data  [NUM_BURSTS*MAX_BEATS];
    strb_t beat_strb  [NUM_BURSTS*MAX_BEATS];
    int    total_beats = 0;

    // What the master really handed over, in order
    logic [AW_BITS-1:0] aw_q [$];
    logic [W_BITS-1:0]  w_q [$];
    int                 beats_in = 0;

    // Monitor state
    int   aw_rd = 0;
    int   w_rd = 0;
    int   out_beat = 0;
    len_t cur_len = '0;
    int   beats_out = 0;
    int   model_errors = 0;
    int   end_errors = 0;
    int   cycle_count = 0;

    logic [31:0] gen_state;
    logic [31:0] gap_state;
    logic [31:0] bp_state;

    wr_path_top i_wr_path_top
    (
        .clk       (clk),
        .rst       (rst),
        .s_awvalid (s_awvalid),
        .s_awid    (s_awid),
        .s_awaddr  (s_awaddr),
        .s_awlen   (s_awlen),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wready  (s_wready),
        .m_awvalid (m_awvalid),
        .m_awid    (m_awid),
        .m_awaddr  (m_awaddr),
        .m_awlen   (m_awlen),
        .m_awready (m_awready),
        .m_wvalid  (m_wvalid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_wready  (m_wready)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            model_errors = model_errors + 1;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // Holds a request on AW until the FIFO takes it; ready is sampled mid-cycle
    task automatic send_aw(input int b);
        logic taken;
        s_awvalid = 1'b1;
        s_awid    = burst_id[b];
        s_awaddr  = burst_addr[b];
        s_awlen   = burst_len[b];
        taken     = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            taken = s_awready;
            @(posedge clk);
            #2;
        end
        aw_q.push_back({burst_id[b], burst_addr[b], burst_len[b]});
        s_awvalid = 1'b0;
    endtask

    task automatic send_w(input int idx);
        logic taken;
        s_wvalid = 1'b1;
        s_wdata  = beat_data[idx];
        s_wstrb  = beat_strb[idx];
        taken    = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            taken = s_wready;
            @(posedge clk);
            #2;
        end
        w_q.push_back({beat_data[idx], beat_strb[idx]});
        beats_in = beats_in + 1;
        s_wvalid = 1'b0;
    endtask

    // Memory-side transfers compared against the accepted stream
    always @(negedge clk)
    begin
        if (!rst && m_wvalid && m_wready && (!m_awvalid || m_awready))
        begin
            if (w_rd >= w_q.size() || (out_beat == 0 && aw_rd >= aw_q.size()))
            begin
                model_errors = model_errors + 1;
                $display("ERROR: a beat left the memory port before the master sent it");
            end
            else
            begin
                check_value($sformatf("beat %0d awvalid", w_rd), out_beat == 0, m_awvalid);
                if (out_beat == 0)
                begin
                    check_value($sformatf("burst %0d id/addr/len", aw_rd), aw_q[aw_rd],
                                {m_awid, m_awaddr, m_awlen});
                    cur_len = aw_q[aw_rd][LEN_W-1:0];
                    aw_rd   = aw_rd + 1;
                end
                check_value($sformatf("beat %0d data/strb", w_rd), w_q[w_rd],
                            {m_wdata, m_wstrb});
                // Last flag belongs on beat len+1 of the burst and nowhere else
                check_value($sformatf("beat %0d wlast", w_rd), out_beat == cur_len, m_wlast);
                w_rd = w_rd + 1;
                if (out_beat == cur_len)
                begin
                    out_beat = 0;
                end
                else
                begin
                    out_beat = out_beat + 1;
                end
            end
            beats_out = beats_out + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout, only %0d of %0d beats reached the memory port",
                     beats_out, total_beats);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial
    begin
        int bp_cycle;
        int chk_errors;
        rst       = 1'b1;
        s_awvalid = 1'b0;
        s_awid    = '0;
        s_awaddr  = '0;
        s_awlen   = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        m_awready = 1'b0;
        m_wready  = 1'b0;

        // Lengths 0 to 7 come from the top bits, where the generator is best
        gen_state = SEED;
        for (int b = 0; b < NUM_BURSTS; b++)
        begin
            gen_state     = lcg_step(gen_state);
            burst_len[b]  = len_t'(gen_state[31:29]);
            burst_id[b]   = gen_state[27:24];
            gen_state     = lcg_step(gen_state);
            burst_addr[b] = {gen_state[31:2], 2'b00};
            for (int k = 0; k <= int'(burst_len[b]); k++)
            begin
                gen_state               = lcg_step(gen_state);
                beat_data[total_beats]  = gen_state;
                beat_strb[total_beats]  = gen_state[19:16];
                total_beats             = total_beats + 1;
            end
        end
        gap_state = lcg_step(gen_state);
        bp_state  = ~gen_state;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        fork
            // First four addresses lag well behind their data
            begin
                for (int b = 0; b < NUM_BURSTS; b++)
                begin
                    if (b < 4)
                    begin
                        repeat (10) @(posedge clk);
                        #2;
                    end
                    send_aw(b);
                end
            end
            begin
                for (int i = 0; i < total_beats; i++)
                begin
                    gap_state = lcg_step(gap_state);
                    if (gap_state[31:30] == 2'b00)
                    begin
                        @(posedge clk);
                        #2;
                    end
                    send_w(i);
                end
            end
            // Random readies with one long stall that backs up into the FIFOs
            begin
                bp_cycle = 0;
                while (beats_out < total_beats)
                begin
                    bp_state = lcg_step(bp_state);
                    if (bp_cycle >= 60 && bp_cycle < 76)
                    begin
                        m_awready = 1'b0;
                        m_wready  = 1'b0;
                    end
                    else
                    begin
                        m_wready  = (bp_state[31:30] != 2'b00);
                        m_awready = (bp_state[29:28] != 2'b00);
                    end
                    bp_cycle = bp_cycle + 1;
                    @(posedge clk);
                    #2;
                end
                m_awready = 1'b1;
                m_wready  = 1'b1;
            end
        join

        repeat (4) @(posedge clk);
        assert (beats_out == beats_in)
        else
        begin
            end_errors = end_errors + 1;
            $display("FAIL beat total expected %0d actual %0d", beats_in, beats_out);
        end
        assert (aw_rd == NUM_BURSTS)
        else
        begin
            end_errors = end_errors + 1;
            $display("FAIL burst total expected %0d actual %0d", NUM_BURSTS, aw_rd);
        end
        chk_errors = i_wr_path_top.u_chk.fail_count;
        $display("Errors: model %0d, end of run %0d, assertions %0d",
                 model_errors, end_errors, chk_errors);
        if (model_errors + end_errors + chk_errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
wlast_pkg.sv
wr_ingress_fifo.sv
burst_sop_tracker.sv
wlast_fixup.sv
wr_skid_slice.sv
wr_path_top.sv
wr_path_chk.sv
tb_wr_path.sv
